// ==== div_unit.f ====
hdl/div_pkg.sv
hdl/restoring_divider.sv
hdl/div_lane.sv
hdl/div_dispatch.sv
hdl/div_collect.sv
hdl/div_unit.sv
dv/div_unit_checker.sv
dv/div_unit_tb.sv

// ==== dv/div_unit_checker.sv ====
`default_nettype none

module div_unit_checker import div_pkg::*; (
    input logic     clk,
    input logic     reset,
    input logic     start,
    input div_req_t req,
    input logic     busy,
    input logic     done,
    input div_rsp_t rsp
);

    localparam int LATENCY     = 34;
    localparam int DRAIN_LIMIT = 200;

    int errors = 0;
    int cycle  = 0;

    // Outstanding requests in issue order
    string            q_name[$];
    logic [TAG_W-1:0] q_tag[$];
    logic [XLEN-1:0]  q_result[$];
    int               q_cycle[$];

    string            next_name  = "";
    bit               next_fixed = 1'b0;
    logic [XLEN-1:0]  next_value = '0;

    // RISC-V M extension results
    function automatic logic [XLEN-1:0] reference_result(div_op_e op, logic [XLEN-1:0] a,
                                                         logic [XLEN-1:0] b);
        if (b == '0) begin
            return (op == OP_DIV || op == OP_DIVU) ? '1 : a;
        end
        if (op == OP_DIVU) return a / b;
        if (op == OP_REMU) return a % b;
        if (a == 32'h8000_0000 && b == '1) return (op == OP_DIV) ? a : '0;
        if (op == OP_DIV) return $signed(a) / $signed(b);
        return $signed(a) % $signed(b);
    endfunction

    // Name and optional hand-computed result for the next start
    task automatic expect_next(input string name, input bit fixed, input logic [XLEN-1:0] value);
        next_name  = name;
        next_fixed = fixed;
        next_value = value;
    endtask

    task automatic drain(output bit ok);
        int waited;
        waited = 0;
        while (q_name.size() != 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        ok = (q_name.size() == 0);
        foreach (q_name[i]) begin
            $display("No response ever arrived for test %s with tag %h", q_name[i], q_tag[i]);
            errors++;
        end
    endtask

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (!reset && done === 1'b1) begin
            if (q_name.size() == 0) begin
                $display("Response with tag %h arrived with no request outstanding", rsp.tag);
                errors++;
            end else begin
                if (cycle != q_cycle[0] + LATENCY) begin
                    $display("Response for test %s arrived on cycle %0d instead of cycle %0d",
                             q_name[0], cycle, q_cycle[0] + LATENCY);
                    errors++;
                end
                if (rsp.tag !== q_tag[0]) begin
                    $display("MISMATCH %s tag expected %h actual %h",
                             q_name[0], q_tag[0], rsp.tag);
                    errors++;
                end
                if (rsp.result !== q_result[0]) begin
                    $display("MISMATCH %s result expected %h actual %h",
                             q_name[0], q_result[0], rsp.result);
                    errors++;
                end
                void'(q_name.pop_front());
                void'(q_tag.pop_front());
                void'(q_result.pop_front());
                void'(q_cycle.pop_front());
            end
        end else if (!reset && done !== 1'b0) begin
            $display("done is unknown on cycle %0d", cycle);
            errors++;
        end
        // Accepted start
        if (!reset && start && !busy) begin
            q_name.push_back(next_name);
            q_tag.push_back(req.tag);
            q_result.push_back(next_fixed ? next_value
                                          : reference_result(req.op, req.dividend, req.divisor));
            q_cycle.push_back(cycle);
        end
    end

endmodule

`default_nettype wire

// ==== dv/div_unit_tb.sv ====
`default_nettype none

module div_unit_tb import div_pkg::*; ();

    localparam int BUSY_LIMIT = 100;

    logic     clk = 1'b0;
    logic     reset;
    logic     start;
    div_req_t req;
    logic     busy;
    logic     done;
    div_rsp_t rsp;

    int seed      = 16746;
    int tb_errors = 0;
    bit timed_out = 1'b0;
    bit drained;

    // Stimulus table
    string           t_name[$];
    div_op_e         t_op[$];
    logic [XLEN-1:0] t_a[$];
    logic [XLEN-1:0] t_b[$];
    logic [XLEN-1:0] t_exp[$];
    bit              t_fixed[$];

    always #4 clk = ~clk;

    div_unit i_div_unit (
        .clk   (clk),
        .reset (reset),
        .start (start),
        .req   (req),
        .busy  (busy),
        .done  (done),
        .rsp   (rsp)
    );

    div_unit_checker i_div_unit_checker (
        .clk   (clk),
        .reset (reset),
        .start (start),
        .req   (req),
        .busy  (busy),
        .done  (done),
        .rsp   (rsp)
    );

    task automatic add_entry(input string name, input div_op_e op, input logic [XLEN-1:0] a,
                             input logic [XLEN-1:0] b, input logic [XLEN-1:0] exp, input bit fixed);
        t_name.push_back(name);
        t_op.push_back(op);
        t_a.push_back(a);
        t_b.push_back(b);
        t_exp.push_back(exp);
        t_fixed.push_back(fixed);
    endtask

    task automatic load_table();
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        int              pick;
        add_entry("divu_basic",    OP_DIVU, 32'd100,       32'd7,         32'd14,        1);
        add_entry("remu_basic",    OP_REMU, 32'd100,       32'd7,         32'd2,         1);
        add_entry("divu_top_bit",  OP_DIVU, 32'hffff_ffff, 32'h10,        32'h0fff_ffff, 1);
        add_entry("remu_top_bit",  OP_REMU, 32'h8000_0005, 32'd3,         32'd1,         1);
        add_entry("div_pos_pos",   OP_DIV,  32'd20,        32'd6,         32'd3,         1);
        add_entry("div_neg_pos",   OP_DIV,  -32'sd20,      32'd6,         -32'sd3,       1);
        add_entry("div_pos_neg",   OP_DIV,  32'd20,        -32'sd6,       -32'sd3,       1);
        add_entry("div_neg_neg",   OP_DIV,  -32'sd20,      -32'sd6,       32'd3,         1);
        add_entry("rem_pos_pos",   OP_REM,  32'd20,        32'd6,         32'd2,         1);
        add_entry("rem_neg_pos",   OP_REM,  -32'sd20,      32'd6,         -32'sd2,       1);
        add_entry("rem_pos_neg",   OP_REM,  32'd20,        -32'sd6,       32'd2,         1);
        add_entry("rem_neg_neg",   OP_REM,  -32'sd20,      -32'sd6,       -32'sd2,       1);
        add_entry("div_by_zero",   OP_DIV,  32'h1234_5678, 32'd0,         32'hffff_ffff, 1);
        add_entry("divu_by_zero",  OP_DIVU, 32'h8765_4321, 32'd0,         32'hffff_ffff, 1);
        add_entry("rem_by_zero",   OP_REM,  32'h8765_4321, 32'd0,         32'h8765_4321, 1);
        add_entry("remu_by_zero",  OP_REMU, 32'hdead_beef, 32'd0,         32'hdead_beef, 1);
        add_entry("div_overflow",  OP_DIV,  32'h8000_0000, 32'hffff_ffff, 32'h8000_0000, 1);
        add_entry("rem_overflow",  OP_REM,  32'h8000_0000, 32'hffff_ffff, 32'd0,         1);
        add_entry("rem_min_by_3",  OP_REM,  32'h8000_0000, 32'd3,         -32'sd2,       1);
        // Random operands with zero and minus one divisors mixed in
        for (int k = 0; k < 40; k++) begin
            a    = $random(seed);
            pick = $random(seed) & 7;
            case (pick)
                0:       b = '0;
                1:       b = '1;
                2, 3:    b = $random(seed) & 32'hff;
                default: b = $random(seed);
            endcase
            add_entry($sformatf("rand_%0d", k), div_op_e'($random(seed) & 3), a, b, '0, 0);
        end
    endtask

    task automatic check_idle(input string when);
        if (busy !== 1'b0 || done !== 1'b0) begin
            $display("busy or done is not low %s", when);
            tb_errors++;
        end
    endtask

    task automatic issue(input int idx);
        int waited;
        waited = 0;
        while (busy && waited < BUSY_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (busy) begin
            $display("Timed out after %0d cycles waiting for busy to drop", BUSY_LIMIT);
            timed_out = 1'b1;
        end else begin
            i_div_unit_checker.expect_next(t_name[idx], t_fixed[idx], t_exp[idx]);
            start        = 1'b1;
            req.op       = t_op[idx];
            req.tag      = TAG_W'(idx);
            req.dividend = t_a[idx];
            req.divisor  = t_b[idx];
            @(negedge clk);
            start = 1'b0;
        end
    endtask

    initial begin
        reset = 1'b1;
        start = 1'b0;
        req   = '0;
        load_table();
        repeat (3) begin
            @(negedge clk);
            check_idle("during reset");
        end
        reset = 1'b0;
        repeat (4) begin
            @(negedge clk);
            check_idle("after reset");
        end
        for (int i = 0; i < t_name.size() && !timed_out; i++) begin
            issue(i);
            // Four back-to-back starts leave the pointer on an occupied lane
            if (i == 3 && busy !== 1'b1) begin
                $display("busy did not rise after all four lanes were filled");
                tb_errors++;
            end
            if (i >= 3) begin
                repeat ($random(seed) & 3) @(negedge clk);
            end
        end
        if (!timed_out) begin
            i_div_unit_checker.drain(drained);
            timed_out = !drained;
        end
        $display("Errors: %0d from checker, %0d from testbench",
                 i_div_unit_checker.errors, tb_errors);
        if (i_div_unit_checker.errors == 0 && tb_errors == 0 && !timed_out) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/div_collect.sv ====
`default_nettype none

module div_collect import div_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [NUM_LANES-1:0] lane_done,
    input  div_rsp_t             lane_rsp [NUM_LANES],
    output logic                 done,
    output div_rsp_t             rsp
);

    logic     any_done;
    div_rsp_t sel_rsp;

    assign any_done = |lane_done;

    // Mux in the single lane that finishes this cycle
    always_comb begin
        sel_rsp = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            if (lane_done[i]) begin
                sel_rsp = lane_rsp[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            done <= 1'b0;
        end else begin
            done <= any_done;
        end
    end

    // Response holds until the next lane finishes
    always_ff @(posedge clk) begin
        if (reset) begin
            rsp <= '0;
        end else if (any_done) begin
            rsp <= sel_rsp;
        end
    end

    // Fixed latency and single issue keep lane completions apart
    a_done_onehot0: assert property (@(posedge clk) disable iff (reset)
        $onehot0(lane_done));

endmodule

`default_nettype wire

// ==== hdl/div_dispatch.sv ====
`default_nettype none

module div_dispatch import div_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 start,
    input  logic [NUM_LANES-1:0] lane_busy,
    output logic [NUM_LANES-1:0] lane_start,
    output logic                 busy
);

    logic [LANE_W-1:0] ptr;
    logic              accept;

    // Only the pointed lane matters for back-pressure
    assign busy   = lane_busy[ptr];
    assign accept = start & ~busy;

    // Decode the strobe onto the pointed lane
    always_comb begin
        lane_start      = '0;
        lane_start[ptr] = accept;
    end

    // Round-robin pointer
    always_ff @(posedge clk) begin
        if (reset) begin
            ptr <= '0;
        end else if (accept) begin
            if (ptr == LANE_W'(NUM_LANES - 1)) begin
                ptr <= '0;
            end else begin
                ptr <= ptr + 1'b1;
            end
        end
    end

    // Source must hold off while the next lane is still working
    a_no_start_when_busy: assert property (@(posedge clk) disable iff (reset)
        start |-> !busy);

endmodule

`default_nettype wire

// ==== hdl/div_lane.sv ====
`default_nettype none

module div_lane import div_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     start,
    input  div_req_t req,
    output logic     busy,
    output logic     done,
    output div_rsp_t rsp
);

    logic             signed_op;
    logic             dvd_neg;
    logic             dvs_neg;
    logic [XLEN-1:0]  dvd_mag;
    logic [XLEN-1:0]  dvs_mag;
    logic [XLEN-1:0]  quo_mag;
    logic [XLEN-1:0]  rem_mag;
    logic             finished;
    logic             active;

    // Request attributes held for the whole divide
    div_op_e          op_q;
    logic [TAG_W-1:0] tag_q;
    logic             quo_neg_q;
    logic             rem_neg_q;
    logic             div_zero_q;

    logic [XLEN-1:0]  quo;
    logic [XLEN-1:0]  rem;

    // Fold signs into magnitudes
    always_comb begin
        signed_op = (req.op == OP_DIV) || (req.op == OP_REM);
        dvd_neg   = signed_op & req.dividend[XLEN-1];
        dvs_neg   = signed_op & req.divisor[XLEN-1];
        dvd_mag   = dvd_neg ? -req.dividend : req.dividend;
        dvs_mag   = dvs_neg ? -req.divisor : req.divisor;
    end

    always_ff @(posedge clk) begin
        if (start) begin
            op_q       <= req.op;
            tag_q      <= req.tag;
            quo_neg_q  <= dvd_neg ^ dvs_neg;
            rem_neg_q  <= dvd_neg;
            div_zero_q <= (req.divisor == '0);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            active <= 1'b0;
        end else if (start) begin
            active <= 1'b1;
        end else if (finished) begin
            active <= 1'b0;
        end
    end

    restoring_divider i_restoring_divider (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .dividend  (dvd_mag),
        .divisor   (dvs_mag),
        .quotient  (quo_mag),
        .remainder (rem_mag),
        .finished  (finished)
    );

    // Restore signs and pick the result
    always_comb begin
        quo = quo_neg_q ? -quo_mag : quo_mag;
        rem = rem_neg_q ? -rem_mag : rem_mag;
        // Divide by zero leaves the dividend in the remainder already
        if (div_zero_q) begin
            quo = '1;
        end
        rsp.tag = tag_q;
        case (op_q)
            OP_DIV, OP_DIVU: rsp.result = quo;
            default:         rsp.result = rem;
        endcase
    end

    assign busy = active;
    assign done = finished;

endmodule

`default_nettype wire

// ==== hdl/div_pkg.sv ====
`default_nettype none

package div_pkg;

    // Datapath and tag widths
    localparam int XLEN  = 32;
    localparam int TAG_W = 4;

    // Lane count and round-robin pointer width
    localparam int NUM_LANES = 4;
    localparam int LANE_W    = 2;

    // One quotient bit per step
    localparam int DIV_STEPS = 32;
    localparam int CNT_W     = 5;

    // M extension divide opcodes
    typedef enum logic [1:0] {
        OP_DIV  = 2'd0,
        OP_DIVU = 2'd1,
        OP_REM  = 2'd2,
        OP_REMU = 2'd3
    } div_op_e;

    // Divider controller states
    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_RUN  = 2'd1,
        ST_DONE = 2'd2
    } div_state_e;

    // 70-bit request into the unit
    typedef struct packed {
        div_op_e           op;
        logic [TAG_W-1:0]  tag;
        logic [XLEN-1:0]   dividend;
        logic [XLEN-1:0]   divisor;
    } div_req_t;

    // 36-bit response out of the unit
    typedef struct packed {
        logic [TAG_W-1:0]  tag;
        logic [XLEN-1:0]   result;
    } div_rsp_t;

endpackage

`default_nettype wire

// ==== hdl/div_unit.sv ====
`default_nettype none

module div_unit import div_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     start,
    input  div_req_t req,
    output logic     busy,
    output logic     done,
    output div_rsp_t rsp
);

    logic [NUM_LANES-1:0] lane_start;
    logic [NUM_LANES-1:0] lane_busy;
    logic [NUM_LANES-1:0] lane_done;
    div_rsp_t             lane_rsp [NUM_LANES];

    div_dispatch i_div_dispatch (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .lane_busy  (lane_busy),
        .lane_start (lane_start),
        .busy       (busy)
    );

    // All lanes share the request bus
    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        div_lane i_div_lane (
            .clk   (clk),
            .reset (reset),
            .start (lane_start[i]),
            .req   (req),
            .busy  (lane_busy[i]),
            .done  (lane_done[i]),
            .rsp   (lane_rsp[i])
        );
    end

    div_collect i_div_collect (
        .clk       (clk),
        .reset     (reset),
        .lane_done (lane_done),
        .lane_rsp  (lane_rsp),
        .done      (done),
        .rsp       (rsp)
    );

endmodule

`default_nettype wire

// ==== hdl/restoring_divider.sv ====
`default_nettype none

module restoring_divider import div_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic            start,
    input  logic [XLEN-1:0] dividend,
    input  logic [XLEN-1:0] divisor,
    output logic [XLEN-1:0] quotient,
    output logic [XLEN-1:0] remainder,
    output logic            finished
);

    div_state_e       state;
    logic [CNT_W-1:0] cnt;

    // Partial remainder (high) and dividend shifting into quotient (low)
    logic [XLEN-1:0]  rem_hi;
    logic [XLEN-1:0]  quo_lo;
    logic [XLEN-1:0]  dvs_q;

    logic [XLEN-1:0]  shifted;
    logic [XLEN:0]    diff;
    logic             q_bit;

    // Shift in the next dividend bit and trial subtract
    always_comb begin
        shifted = {rem_hi[XLEN-2:0], quo_lo[XLEN-1]};
        diff    = {1'b0, shifted} - {1'b0, dvs_q};
        // A set top bit means the true partial remainder is above the divisor
        q_bit   = rem_hi[XLEN-1] | ~diff[XLEN];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state <= ST_RUN;
                    end
                end
                ST_RUN: begin
                    if (cnt == CNT_W'(DIV_STEPS - 1)) begin
                        cnt   <= '0;
                        state <= ST_DONE;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                ST_DONE: state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Datapath
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && start) begin
            rem_hi <= '0;
            quo_lo <= dividend;
            dvs_q  <= divisor;
        end else if (state == ST_RUN) begin
            rem_hi <= q_bit ? diff[XLEN-1:0] : shifted;
            quo_lo <= {quo_lo[XLEN-2:0], q_bit};
        end
    end

    assign quotient  = quo_lo;
    assign remainder = rem_hi;
    assign finished  = (state == ST_DONE);

    // Step counter must be parked outside the run phase
    a_cnt_parked: assert property (@(posedge clk) disable iff (reset)
        (state != ST_RUN) |-> (cnt == '0));

endmodule

`default_nettype wire
